/* nibble_core.f */
hdl/isa_pkg.sv
hdl/state_pkg.sv
hdl/decode_stage.sv
hdl/operand_stage.sv
hdl/alu_stage.sv
hdl/writeback_stage.sv
hdl/arch_state.sv
hdl/nibble_core.sv
bench/nibble_core_sva.sv
bench/nibble_core_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and search the output for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module nibble_core_tb \
  -f nibble_core.f -Mdir obj_dir -o nibble_core_sim &&
./obj_dir/nibble_core_sim +verilator+error+limit+100 | tee /dev/stderr |
  grep -q "Regression passed" &&
echo "simulation ok" || { echo "build or simulation did not pass"; exit 1; }

/* bench/nibble_core_tb.sv */
`timescale 1ns/1ps

module nibble_core_tb;

  logic clk;
  logic rst_n;
  logic in_valid;
  logic in_ready;
  logic [isa_pkg::instr_w-1:0] in_instr;
  logic retire_valid;
  logic retire_ready;
  isa_pkg::loc_e retire_dst;
  logic [state_pkg::nibble_w-1:0] retire_result;
  logic retire_carry;
  logic retire_zero;
  logic retire_illegal;

  // expected retire stream, one entry per instruction.
  string t_name [$];
  logic [isa_pkg::instr_w-1:0] t_word [$];
  isa_pkg::loc_e t_dst [$];
  logic [3:0] t_res [$];
  logic t_carry [$];
  logic t_zero [$];
  logic t_ill [$];
  logic [1:0] t_chk [$];  // bit 1 checks retire_dst, bit 0 retire_result.

  // reference architectural state.
  logic [3:0] m_a, m_b, m_x, m_y;
  logic [3:0] m_ram [state_pkg::ram_words];
  logic m_c;
  logic m_z;

  int n_failed;
  int n_errors;
  int n_other;

  nibble_core DUT (
    .clk, .rst_n, .in_valid, .in_ready, .in_instr,
    .retire_valid, .retire_ready, .retire_dst, .retire_result,
    .retire_carry, .retire_zero, .retire_illegal
  );

  function automatic logic [3:0] model_read(isa_pkg::loc_e loc);
    case (loc)
      isa_pkg::LOC_A:  return m_a;
      isa_pkg::LOC_B:  return m_b;
      isa_pkg::LOC_MX: return m_ram[m_x];
      default:         return m_ram[m_y];
    endcase
  endfunction

  task automatic model_write(input isa_pkg::loc_e loc, input logic [3:0] val);
    case (loc)
      isa_pkg::LOC_A:  m_a = val;
      isa_pkg::LOC_B:  m_b = val;
      isa_pkg::LOC_MX: m_ram[m_x] = val;
      default:         m_ram[m_y] = val;
    endcase
  endtask

  task automatic push_entry(input string name, input logic [11:0] word,
                            input isa_pkg::loc_e dst, input logic [3:0] res,
                            input logic [1:0] chk, input logic ill);
    t_name.push_back(name);
    t_word.push_back(word);
    t_dst.push_back(dst);
    t_res.push_back(res);
    t_carry.push_back(m_c); // flags as they stand once this entry commits.
    t_zero.push_back(m_z);
    t_ill.push_back(ill);
    t_chk.push_back(chk);
  endtask

  task automatic exec_op(input string name, input isa_pkg::opcode_e op,
                         input isa_pkg::loc_e r, input isa_pkg::loc_e q,
                         input logic [3:0] imm);
    logic [11:0] word;
    logic [3:0] lhs;
    logic [3:0] rhs;
    logic [4:0] res;
    lhs = model_read(r);
    rhs = imm;
    case (op)
      isa_pkg::AND_RR: word = {isa_pkg::rr_and, r, q};
      isa_pkg::OR_RR:  word = {isa_pkg::rr_or, r, q};
      isa_pkg::XOR_RR: word = {isa_pkg::rr_xor, r, q};
      isa_pkg::ADD_RR: word = {isa_pkg::rr_add, r, q};
      isa_pkg::AND_RI: word = {isa_pkg::ri_and, r, imm};
      isa_pkg::OR_RI:  word = {isa_pkg::ri_or, r, imm};
      isa_pkg::ADD_RI: word = {isa_pkg::ri_add, r, imm};
      default:         word = {isa_pkg::ri_ld, r, imm};
    endcase
    if (op inside {isa_pkg::AND_RR, isa_pkg::OR_RR, isa_pkg::XOR_RR, isa_pkg::ADD_RR}) begin
      rhs = model_read(q);
    end
    case (op)
      isa_pkg::AND_RR, isa_pkg::AND_RI: res = {1'b0, lhs & rhs};
      isa_pkg::OR_RR, isa_pkg::OR_RI:   res = {1'b0, lhs | rhs};
      isa_pkg::XOR_RR:                  res = {1'b0, lhs ^ rhs};
      isa_pkg::ADD_RR, isa_pkg::ADD_RI: begin
        res = {1'b0, lhs} + {1'b0, rhs};
        m_c = res[4];
      end
      default: res = {1'b0, rhs};
    endcase
    m_z = (res[3:0] == 4'h0);
    model_write(r, res[3:0]);
    push_entry(name, word, r, res[3:0], 2'b11, 1'b0);
  endtask

  task automatic exec_ptr(input string name, input logic to_y, input logic [3:0] val);
    logic [5:0] opc;
    opc = to_y ? isa_pkg::ri_ldy : isa_pkg::ri_ldx;
    if (to_y) begin
      m_y = val;
    end else begin
      m_x = val;
    end
    push_entry(name, {opc, 2'b00, val}, isa_pkg::LOC_A, val, 2'b01, 1'b0);
  endtask

  task automatic exec_raw(input string name, input logic [11:0] word, input logic ill);
    push_entry(name, word, isa_pkg::LOC_A, 4'h0, 2'b00, ill);
  endtask

  task automatic build_table();
    logic [3:0] init_val [4];
    isa_pkg::opcode_e op;
    init_val = '{4'h1, 4'h8, 4'h5, 4'hE};
    m_a = state_pkg::reset_nibble;
    m_b = state_pkg::reset_nibble;
    m_x = state_pkg::reset_nibble;
    m_y = state_pkg::reset_nibble;
    for (int i = 0; i < state_pkg::ram_words; i++) m_ram[i] = state_pkg::reset_nibble;
    m_c = state_pkg::reset_carry;
    m_z = state_pkg::reset_zero;
    exec_ptr("ldx_pairs", 1'b0, 4'h3);
    exec_ptr("ldy_pairs", 1'b1, 4'h9);
    for (int r = 0; r < 4; r++) begin
      for (int q = 0; q < 4; q++) begin
        for (int k = 0; k < 4; k++) begin  // every pair starts from the same four values.
          exec_op($sformatf("reload_%0d", k), isa_pkg::LD_RI, isa_pkg::loc_e'(k[1:0]),
                  isa_pkg::LOC_A, init_val[k]);
        end
        exec_op($sformatf("and_rr_%0d_%0d", r, q), isa_pkg::AND_RR,
                isa_pkg::loc_e'(r[1:0]), isa_pkg::loc_e'(q[1:0]), 4'h0);
      end
    end
    for (int r = 0; r < 4; r++) begin
      exec_op($sformatf("ld_ri_%0d", r), isa_pkg::LD_RI, isa_pkg::loc_e'(r[1:0]),
              isa_pkg::LOC_A, r[3:0] + 4'h6);
      exec_op($sformatf("and_ri_%0d", r), isa_pkg::AND_RI, isa_pkg::loc_e'(r[1:0]),
              isa_pkg::LOC_A, 4'h3);
      exec_op($sformatf("or_ri_%0d", r), isa_pkg::OR_RI, isa_pkg::loc_e'(r[1:0]),
              isa_pkg::LOC_A, 4'h8);
      exec_op($sformatf("add_ri_%0d", r), isa_pkg::ADD_RI, isa_pkg::loc_e'(r[1:0]),
              isa_pkg::LOC_A, 4'h9);
    end
    exec_op("ld_a_9", isa_pkg::LD_RI, isa_pkg::LOC_A, isa_pkg::LOC_A, 4'h9);
    exec_op("ld_b_7", isa_pkg::LD_RI, isa_pkg::LOC_B, isa_pkg::LOC_A, 4'h7);
    exec_op("add_wraps_to_zero", isa_pkg::ADD_RR, isa_pkg::LOC_A, isa_pkg::LOC_B, 4'h0);
    exec_op("xor_keeps_carry", isa_pkg::XOR_RR, isa_pkg::LOC_B, isa_pkg::LOC_A, 4'h0);
    exec_op("and_keeps_carry", isa_pkg::AND_RI, isa_pkg::LOC_A, isa_pkg::LOC_A, 4'h0);
    exec_op("add_clears_carry", isa_pkg::ADD_RI, isa_pkg::LOC_A, isa_pkg::LOC_A, 4'h1);
    exec_ptr("ldx_dep", 1'b0, 4'h7);
    exec_op("st_mx_after_ldx", isa_pkg::LD_RI, isa_pkg::LOC_MX, isa_pkg::LOC_A, 4'hC);
    exec_op("ld_a_f", isa_pkg::LD_RI, isa_pkg::LOC_A, isa_pkg::LOC_A, 4'hF);
    exec_op("and_a_mx", isa_pkg::AND_RR, isa_pkg::LOC_A, isa_pkg::LOC_MX, 4'h0);
    exec_ptr("ldy_alias", 1'b1, 4'h7);
    exec_op("add_my_mx", isa_pkg::ADD_RR, isa_pkg::LOC_MY, isa_pkg::LOC_MX, 4'h0);
    exec_op("add_b_3", isa_pkg::ADD_RI, isa_pkg::LOC_B, isa_pkg::LOC_A, 4'h3);
    exec_op("add_a_b", isa_pkg::ADD_RR, isa_pkg::LOC_A, isa_pkg::LOC_B, 4'h0);
    exec_op("or_mx_a", isa_pkg::OR_RR, isa_pkg::LOC_MX, isa_pkg::LOC_A, 4'h0);
    exec_raw("illegal_000", 12'h000, 1'b1);
    exec_op("after_illegal", isa_pkg::OR_RI, isa_pkg::LOC_A, isa_pkg::LOC_A, 4'h0);
    exec_raw("illegal_7ff", 12'h7FF, 1'b1);
    exec_raw("nop", isa_pkg::nop_word, 1'b0);
    exec_op("after_nop", isa_pkg::ADD_RR, isa_pkg::LOC_A, isa_pkg::LOC_A, 4'h0);
    for (int i = 0; i < 32; i++) begin
      if (i % 8 == 0) begin
        exec_ptr($sformatf("rand_ptr_%0d", i), i[3], 4'($urandom_range(15)));
      end
      op = isa_pkg::opcode_e'(4'($urandom_range(8, 1)));
      exec_op($sformatf("rand_%0d", i), op, isa_pkg::loc_e'(2'($urandom_range(3))),
              isa_pkg::loc_e'(2'($urandom_range(3))), 4'($urandom_range(15)));
    end
  endtask

  task automatic check_loc(input string test, input string field,
                           input isa_pkg::loc_e exp, input isa_pkg::loc_e act);
    if (exp !== act) begin
      n_errors++;
      $display("ERROR %s %s: expected %s, actual %s", test, field, exp.name(), act.name());
    end
  endtask

  task automatic check_nibble(input string test, input string field,
                              input logic [state_pkg::nibble_w-1:0] exp,
                              input logic [state_pkg::nibble_w-1:0] act);
    if (exp !== act) begin
      n_errors++;
      $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input string field,
                            input logic exp, input logic act);
    if (exp !== act) begin
      n_errors++;
      $display("ERROR %s %s: expected %b, actual %b", test, field, exp, act);
    end
  endtask

  task automatic drive_inputs();
    for (int i = 0; i < t_word.size(); i++) begin
      @(negedge clk);
      while ($urandom_range(3) == 0) begin
        in_valid = 1'b0;
        @(negedge clk);
      end
      in_valid = 1'b1;
      in_instr = t_word[i];
      #1;
      while (!in_ready) begin // held until the core takes it.
        @(negedge clk);
        #1;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic watch_retire();
    int k;
    int err_before;
    k = 0;
    while (k < t_word.size()) begin
      @(negedge clk);
      retire_ready = ($urandom_range(3) != 0);
      #1;
      if (retire_valid && retire_ready) begin
        err_before = n_errors;
        if (t_chk[k][1]) check_loc(t_name[k], "dst", t_dst[k], retire_dst);
        if (t_chk[k][0]) check_nibble(t_name[k], "result", t_res[k], retire_result);
        check_flag(t_name[k], "carry", t_carry[k], retire_carry);
        check_flag(t_name[k], "zero", t_zero[k], retire_zero);
        check_flag(t_name[k], "illegal", t_ill[k], retire_illegal);
        if (n_errors != err_before) n_failed++;
        $display("test %0d %s %s", k, t_name[k], (n_errors == err_before) ? "ok" : "mismatch");
        k++;
      end
    end
    repeat (8) begin
      @(negedge clk);
      retire_ready = 1'b1;
      #1;
      if (retire_valid) begin
        n_other++;
        $display("an instruction retired after the last expected one");
      end
    end
  endtask

  task automatic run_watchdog();
    repeat (t_word.size() * 20) @(posedge clk);
    n_other++;
    $display("timeout after %0d cycles with retirement unfinished", t_word.size() * 20);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_instr = isa_pkg::nop_word;
    retire_ready = 1'b0;
    n_failed = 0;
    n_errors = 0;
    n_other = 0;
    void'($urandom(60));
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_inputs();
    join_none
    fork
      watch_retire();
      run_watchdog();
    join_any
    n_other += DUT.u_sva.fail_count;
    $display("tests %0d, failed %0d, other failures %0d", t_word.size(), n_failed, n_other);
    if (n_failed == 0 && n_other == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* bench/nibble_core_sva.sv */
`timescale 1ns/1ps

module nibble_core_sva (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic in_ready,
  input logic [isa_pkg::instr_w-1:0] in_instr,
  input logic retire_valid,
  input logic retire_ready,
  input isa_pkg::loc_e retire_dst,
  input logic [state_pkg::nibble_w-1:0] retire_result,
  input logic retire_carry,
  input logic retire_zero,
  input logic retire_illegal
);

  int fail_count = 0;

  // the sender keeps valid and payload until the transfer.
  in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_instr))
    else begin
      fail_count++;
      $error("in_valid dropped or in_instr changed before in_ready");
    end

  retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid &&
    $stable({retire_dst, retire_result, retire_carry, retire_zero, retire_illegal}))
    else begin
      fail_count++;
      $error("retire_valid dropped or retire payload changed before retire_ready");
    end

  reset_idle: assert property (@(posedge clk) !rst_n |=> !retire_valid)
    else begin
      fail_count++;
      $error("retire_valid high in the cycle after reset");
    end

  retire_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(retire_valid))
    else begin
      fail_count++;
      $error("retire_valid is unknown");
    end

endmodule

bind nibble_core nibble_core_sva u_sva (
  .clk, .rst_n, .in_valid, .in_ready, .in_instr, .retire_valid, .retire_ready,
  .retire_dst, .retire_result, .retire_carry, .retire_zero, .retire_illegal
);

/* hdl/nibble_core.sv */
`timescale 1ns/1ps

module nibble_core (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  logic [isa_pkg::instr_w-1:0] in_instr,
  output logic retire_valid,
  input  logic retire_ready,
  output isa_pkg::loc_e retire_dst,
  output logic [state_pkg::nibble_w-1:0] retire_result,
  output logic retire_carry,
  output logic retire_zero,
  output logic retire_illegal
);

  logic dec_valid, dec_ready;
  isa_pkg::opcode_e dec_op;
  isa_pkg::loc_e dec_dst, dec_src;
  logic [isa_pkg::imm_w-1:0] dec_imm;

  logic opr_valid, opr_ready;
  isa_pkg::opcode_e opr_op;
  isa_pkg::loc_e opr_dst;
  logic [state_pkg::nibble_w-1:0] opr_addr, opr_a, opr_b;

  logic alu_valid, alu_ready, alu_carry;
  isa_pkg::opcode_e alu_op;
  isa_pkg::loc_e alu_dst, alu_busy_dst, wb_busy_dst;
  logic [state_pkg::nibble_w-1:0] alu_addr, alu_result;
  logic alu_busy_valid, alu_busy_ptr, wb_busy_valid, wb_busy_ptr;

  logic wr_en, carry_en, carry_in, zero_en, zero_in;
  isa_pkg::wr_loc_e wr_loc;
  logic [state_pkg::nibble_w-1:0] wr_addr, wr_data;

  logic [state_pkg::nibble_w-1:0] st_a, st_b, st_x, st_y, st_mem_x, st_mem_y;
  logic st_carry, st_zero;

  decode_stage u_decode (
    .clk, .rst_n, .in_valid, .in_ready, .in_instr,
    .out_valid(dec_valid), .out_ready(dec_ready),
    .op(dec_op), .dst(dec_dst), .src(dec_src), .imm(dec_imm)
  );

  operand_stage u_operand (
    .clk, .rst_n, .in_valid(dec_valid), .in_ready(dec_ready),
    .op(dec_op), .dst(dec_dst), .src(dec_src), .imm(dec_imm),
    .a(st_a), .b(st_b), .x(st_x), .y(st_y), .mem_x(st_mem_x), .mem_y(st_mem_y),
    .alu_busy_dst, .alu_busy_valid, .alu_busy_ptr,
    .wb_busy_dst, .wb_busy_valid, .wb_busy_ptr,
    .out_valid(opr_valid), .out_ready(opr_ready), .out_op(opr_op), .out_dst(opr_dst),
    .out_addr(opr_addr), .opa(opr_a), .opb(opr_b)
  );

  alu_stage u_alu (
    .clk, .rst_n, .in_valid(opr_valid), .in_ready(opr_ready),
    .op(opr_op), .dst(opr_dst), .addr(opr_addr), .opa(opr_a), .opb(opr_b),
    .out_valid(alu_valid), .out_ready(alu_ready), .out_op(alu_op), .out_dst(alu_dst),
    .out_addr(alu_addr), .result(alu_result), .carry_out(alu_carry),
    .busy_dst(alu_busy_dst), .busy_valid(alu_busy_valid), .busy_ptr(alu_busy_ptr)
  );

  writeback_stage u_writeback (
    .clk, .rst_n, .in_valid(alu_valid), .in_ready(alu_ready),
    .op(alu_op), .dst(alu_dst), .addr(alu_addr), .result(alu_result),
    .carry_out(alu_carry), .carry_now(st_carry), .zero_now(st_zero),
    .wr_en, .wr_loc, .wr_addr, .wr_data, .carry_en, .carry_in, .zero_en, .zero_in,
    .busy_dst(wb_busy_dst), .busy_valid(wb_busy_valid), .busy_ptr(wb_busy_ptr),
    .retire_valid, .retire_ready, .retire_dst, .retire_result,
    .retire_carry, .retire_zero, .retire_illegal
  );

  arch_state u_state (
    .clk, .rst_n,
    .a(st_a), .b(st_b), .x(st_x), .y(st_y), .carry(st_carry), .zero(st_zero),
    .mem_x(st_mem_x), .mem_y(st_mem_y),
    .wr_en, .wr_loc, .wr_addr, .wr_data, .carry_en, .carry_in, .zero_en, .zero_in
  );

endmodule

/* hdl/arch_state.sv */
`timescale 1ns/1ps

module arch_state (
  input  logic clk,
  input  logic rst_n,
  output logic [state_pkg::nibble_w-1:0] a,
  output logic [state_pkg::nibble_w-1:0] b,
  output logic [state_pkg::nibble_w-1:0] x,
  output logic [state_pkg::nibble_w-1:0] y,
  output logic carry,
  output logic zero,
  output logic [state_pkg::nibble_w-1:0] mem_x,
  output logic [state_pkg::nibble_w-1:0] mem_y,
  input  logic wr_en,
  input  isa_pkg::wr_loc_e wr_loc,
  input  logic [state_pkg::nibble_w-1:0] wr_addr,
  input  logic [state_pkg::nibble_w-1:0] wr_data,
  input  logic carry_en,
  input  logic carry_in,
  input  logic zero_en,
  input  logic zero_in
);

  logic [state_pkg::nibble_w-1:0] ram [state_pkg::ram_words];

  assign mem_x = ram[x];
  assign mem_y = ram[y];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a <= state_pkg::reset_nibble;
      b <= state_pkg::reset_nibble;
      x <= state_pkg::reset_nibble;
      y <= state_pkg::reset_nibble;
      carry <= state_pkg::reset_carry;
      zero <= state_pkg::reset_zero;
      for (int i = 0; i < state_pkg::ram_words; i++) begin
        ram[i] <= state_pkg::reset_nibble;
      end
    end else begin
      if (carry_en) begin
        carry <= carry_in;
      end
      if (zero_en) begin
        zero <= zero_in;
      end
      if (wr_en) begin
        case (wr_loc)
          isa_pkg::WR_A: a <= wr_data;
          isa_pkg::WR_B: b <= wr_data;
          isa_pkg::WR_MX, isa_pkg::WR_MY: ram[wr_addr] <= wr_data; // address taken at operand read.
          isa_pkg::WR_X: x <= wr_data;
          isa_pkg::WR_Y: y <= wr_data;
          default: ;
        endcase
      end
    end
  end

endmodule

/* hdl/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  isa_pkg::opcode_e op,
  input  isa_pkg::loc_e dst,
  input  logic [state_pkg::nibble_w-1:0] addr,
  input  logic [state_pkg::nibble_w-1:0] result,
  input  logic carry_out,
  input  logic carry_now,
  input  logic zero_now,
  output logic wr_en,
  output isa_pkg::wr_loc_e wr_loc,
  output logic [state_pkg::nibble_w-1:0] wr_addr,
  output logic [state_pkg::nibble_w-1:0] wr_data,
  output logic carry_en,
  output logic carry_in,
  output logic zero_en,
  output logic zero_in,
  output isa_pkg::loc_e busy_dst,
  output logic busy_valid,
  output logic busy_ptr,
  output logic retire_valid,
  input  logic retire_ready,
  output isa_pkg::loc_e retire_dst,
  output logic [state_pkg::nibble_w-1:0] retire_result,
  output logic retire_carry,
  output logic retire_zero,
  output logic retire_illegal
);

  isa_pkg::opcode_e op_q;
  logic carry_q;
  logic commit;
  logic wrote;
  logic [state_pkg::nibble_w-1:0] addr_q;

  assign in_ready = !retire_valid || retire_ready;
  assign commit = retire_valid && retire_ready;  // state changes only on retire.
  assign wrote = isa_pkg::writes_loc(op_q);

  assign wr_en = commit && (wrote || isa_pkg::loads_ptr(op_q));
  assign wr_loc = isa_pkg::loads_ptr(op_q) ?
                  ((retire_dst == isa_pkg::LOC_MY) ? isa_pkg::WR_Y : isa_pkg::WR_X) :
                  isa_pkg::wr_loc_e'({1'b0, retire_dst});
  assign wr_addr = addr_q;
  assign wr_data = retire_result;
  assign carry_en = commit && isa_pkg::is_add(op_q);
  assign carry_in = carry_q;
  assign zero_en = commit && wrote;
  assign zero_in = (retire_result == '0);

  // logic ops keep the carry that is current at commit.
  assign retire_carry = isa_pkg::is_add(op_q) ? carry_q : carry_now;
  assign retire_zero = wrote ? zero_in : zero_now;
  assign retire_illegal = (op_q == isa_pkg::ILLEGAL);

  assign busy_dst = retire_dst;
  assign busy_valid = retire_valid && wrote;
  assign busy_ptr = retire_valid && isa_pkg::loads_ptr(op_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
    end else if (in_ready) begin
      retire_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      op_q <= op;
      retire_dst <= dst;
      addr_q <= addr;
      retire_result <= result;
      carry_q <= carry_out;
    end
  end

endmodule

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  isa_pkg::opcode_e op,
  input  isa_pkg::loc_e dst,
  input  logic [state_pkg::nibble_w-1:0] addr,
  input  logic [state_pkg::nibble_w-1:0] opa,
  input  logic [state_pkg::nibble_w-1:0] opb,
  output logic out_valid,
  input  logic out_ready,
  output isa_pkg::opcode_e out_op,
  output isa_pkg::loc_e out_dst,
  output logic [state_pkg::nibble_w-1:0] out_addr,
  output logic [state_pkg::nibble_w-1:0] result,
  output logic carry_out,
  output isa_pkg::loc_e busy_dst,
  output logic busy_valid,
  output logic busy_ptr
);

  logic [state_pkg::nibble_w-1:0] res_d;
  logic carry_d;

  always_comb begin
    carry_d = 1'b0;
    case (op)
      isa_pkg::AND_RR, isa_pkg::AND_RI: res_d = opa & opb;
      isa_pkg::OR_RR, isa_pkg::OR_RI:   res_d = opa | opb;
      isa_pkg::XOR_RR:                  res_d = opa ^ opb;
      isa_pkg::ADD_RR, isa_pkg::ADD_RI: {carry_d, res_d} = {1'b0, opa} + {1'b0, opb};
      isa_pkg::LD_RI, isa_pkg::LDX, isa_pkg::LDY: res_d = opb; // immediate passes through.
      default: res_d = '0;
    endcase
  end

  assign in_ready = !out_valid || out_ready;

  assign busy_dst = out_dst;
  assign busy_valid = out_valid && isa_pkg::writes_loc(out_op);
  assign busy_ptr = out_valid && isa_pkg::loads_ptr(out_op);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_op <= op;
      out_dst <= dst;
      out_addr <= addr;
      result <= res_d;
      carry_out <= carry_d;
    end
  end

endmodule

/* hdl/operand_stage.sv */
`timescale 1ns/1ps

module operand_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  isa_pkg::opcode_e op,
  input  isa_pkg::loc_e dst,
  input  isa_pkg::loc_e src,
  input  logic [isa_pkg::imm_w-1:0] imm,
  input  logic [state_pkg::nibble_w-1:0] a,
  input  logic [state_pkg::nibble_w-1:0] b,
  input  logic [state_pkg::nibble_w-1:0] x,
  input  logic [state_pkg::nibble_w-1:0] y,
  input  logic [state_pkg::nibble_w-1:0] mem_x,
  input  logic [state_pkg::nibble_w-1:0] mem_y,
  input  isa_pkg::loc_e alu_busy_dst,
  input  logic alu_busy_valid,
  input  logic alu_busy_ptr,
  input  isa_pkg::loc_e wb_busy_dst,
  input  logic wb_busy_valid,
  input  logic wb_busy_ptr,
  output logic out_valid,
  input  logic out_ready,
  output isa_pkg::opcode_e out_op,
  output isa_pkg::loc_e out_dst,
  output logic [state_pkg::nibble_w-1:0] out_addr,
  output logic [state_pkg::nibble_w-1:0] opa,
  output logic [state_pkg::nibble_w-1:0] opb
);

  logic valid;
  isa_pkg::loc_e src_q;
  logic [isa_pkg::imm_w-1:0] imm_q;
  logic [3:0][state_pkg::nibble_w-1:0] loc_val;
  logic rd_src;
  logic dst_hit;
  logic src_hit;
  logic hazard;

  // any pending RAM write blocks any RAM read, since x and y may alias.
  function automatic logic clash(isa_pkg::loc_e loc, logic ptr_only,
                                 isa_pkg::loc_e bdst, logic bvalid, logic bptr);
    logic word_hit;
    word_hit = bvalid && !ptr_only && (loc[1] ? bdst[1] : bdst == loc);
    return word_hit || (bptr && bdst == loc);  // RAM access through a pending pointer.
  endfunction

  assign loc_val = {mem_y, mem_x, b, a};
  assign rd_src = out_op inside {isa_pkg::AND_RR, isa_pkg::OR_RR, isa_pkg::XOR_RR,
                                 isa_pkg::ADD_RR};

  always_comb begin
    dst_hit = clash(out_dst, out_op == isa_pkg::LD_RI, alu_busy_dst, alu_busy_valid,
                    alu_busy_ptr) ||
              clash(out_dst, out_op == isa_pkg::LD_RI, wb_busy_dst, wb_busy_valid,
                    wb_busy_ptr);
    src_hit = clash(src_q, 1'b0, alu_busy_dst, alu_busy_valid, alu_busy_ptr) ||
              clash(src_q, 1'b0, wb_busy_dst, wb_busy_valid, wb_busy_ptr);
    hazard = valid && ((isa_pkg::writes_loc(out_op) && dst_hit) || (rd_src && src_hit));
  end

  assign out_valid = valid && !hazard;
  assign in_ready = !valid || (out_ready && !hazard);

  assign opa = loc_val[out_dst];
  assign opb = rd_src ? loc_val[src_q] : imm_q;
  assign out_addr = (out_dst == isa_pkg::LOC_MY) ? y : x;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (in_ready) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_op <= op;
      out_dst <= dst;
      src_q <= src;
      imm_q <= imm;
    end
  end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  logic [isa_pkg::instr_w-1:0] in_instr,
  output logic out_valid,
  input  logic out_ready,
  output isa_pkg::opcode_e op,
  output isa_pkg::loc_e dst,
  output isa_pkg::loc_e src,
  output logic [isa_pkg::imm_w-1:0] imm
);

  isa_pkg::opcode_e op_d;
  isa_pkg::loc_e dst_d;

  assign in_ready = !out_valid || out_ready;

  always_comb begin
    op_d = isa_pkg::ILLEGAL;
    dst_d = isa_pkg::loc_e'(in_instr[3:2]);
    if (in_instr == isa_pkg::nop_word) begin
      op_d = isa_pkg::NOP;
    end else begin
      case (in_instr[isa_pkg::instr_w-1 -: isa_pkg::rr_op_w])
        isa_pkg::rr_and: op_d = isa_pkg::AND_RR;
        isa_pkg::rr_or:  op_d = isa_pkg::OR_RR;
        isa_pkg::rr_xor: op_d = isa_pkg::XOR_RR;
        isa_pkg::rr_add: op_d = isa_pkg::ADD_RR;
        default: begin
          dst_d = isa_pkg::loc_e'(in_instr[5:4]); // r sits higher in the immediate form.
          case (in_instr[isa_pkg::instr_w-1 -: isa_pkg::ri_op_w])
            isa_pkg::ri_and: op_d = isa_pkg::AND_RI;
            isa_pkg::ri_or:  op_d = isa_pkg::OR_RI;
            isa_pkg::ri_add: op_d = isa_pkg::ADD_RI;
            isa_pkg::ri_ld:  op_d = isa_pkg::LD_RI;
            isa_pkg::ri_ldx: begin
              op_d = isa_pkg::LDX;
              dst_d = isa_pkg::LOC_MX;  // tags the x pointer downstream.
            end
            isa_pkg::ri_ldy: begin
              op_d = isa_pkg::LDY;
              dst_d = isa_pkg::LOC_MY;
            end
            default: op_d = isa_pkg::ILLEGAL;
          endcase
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      op <= op_d;
      dst <= dst_d;
      src <= isa_pkg::loc_e'(in_instr[1:0]);
      imm <= in_instr[isa_pkg::imm_w-1:0];
    end
  end

endmodule

/* hdl/state_pkg.sv */
package state_pkg;

  localparam int nibble_w = 4;
  localparam int ram_words = 16;  // addressed by a full nibble pointer.

  // values after reset.
  localparam logic [nibble_w-1:0] reset_nibble = 4'h0;
  localparam logic reset_carry = 1'b0;
  localparam logic reset_zero = 1'b1;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

  localparam int instr_w = 12;
  localparam int rr_op_w = 8;   // register-register opcode, bits 11..4.
  localparam int ri_op_w = 6;   // immediate opcode, bits 11..6.
  localparam int loc_w = 2;
  localparam int imm_w = 4;

  typedef enum logic [3:0] {
    NOP, AND_RR, OR_RR, XOR_RR, ADD_RR, AND_RI, OR_RI, ADD_RI, LD_RI, LDX, LDY, ILLEGAL
  } opcode_e;

  typedef enum logic [loc_w-1:0] {LOC_A, LOC_B, LOC_MX, LOC_MY} loc_e;

  // write targets of the state block; the first four share the loc_e codes.
  typedef enum logic [2:0] {WR_A, WR_B, WR_MX, WR_MY, WR_X, WR_Y} wr_loc_e;

  localparam logic [rr_op_w-1:0] rr_and = 8'hAC;
  localparam logic [rr_op_w-1:0] rr_or  = 8'hAD;
  localparam logic [rr_op_w-1:0] rr_xor = 8'hAE;
  localparam logic [rr_op_w-1:0] rr_add = 8'hA8;

  localparam logic [ri_op_w-1:0] ri_add = 6'b110000;
  localparam logic [ri_op_w-1:0] ri_and = 6'b110010;
  localparam logic [ri_op_w-1:0] ri_or  = 6'b110011;
  localparam logic [ri_op_w-1:0] ri_ld  = 6'b111000;
  localparam logic [ri_op_w-1:0] ri_ldx = 6'b111001;  // r field ignored.
  localparam logic [ri_op_w-1:0] ri_ldy = 6'b111010;

  localparam logic [instr_w-1:0] nop_word = 12'hFFB;

  // instructions that write a, b or a RAM word.
  function automatic logic writes_loc(opcode_e op);
    return op inside {AND_RR, OR_RR, XOR_RR, ADD_RR, AND_RI, OR_RI, ADD_RI, LD_RI};
  endfunction

  function automatic logic loads_ptr(opcode_e op);
    return op inside {LDX, LDY};
  endfunction

  function automatic logic is_add(opcode_e op);
    return op inside {ADD_RR, ADD_RI};
  endfunction

endpackage
